//--- source/mem_pipe_pkg.sv
`default_nettype none

package mem_pipe_pkg;

    // one data word on the pipeline side
    typedef logic [31:0] word_t;

    // access width of a load or store
    typedef enum logic [1:0] {
        MSIZE_BYTE = 2'd0,
        MSIZE_HALF = 2'd1,
        MSIZE_WORD = 2'd2
    } msize_t;

    // lane 0 is the older instruction
    typedef logic lane_idx_t;

    // pull the addressed field out of a read word and extend it
    function automatic word_t extract_load(
        input word_t      raw,
        input logic [1:0] offset,
        input msize_t     size,
        input logic       is_unsigned
    );
        word_t shifted;
        shifted = raw >> {offset, 3'b000};
        case (size)
            MSIZE_BYTE:
                return is_unsigned ? {24'b0, shifted[7:0]}
                                   : {{24{shifted[7]}}, shifted[7:0]};
            MSIZE_HALF:
                return is_unsigned ? {16'b0, shifted[15:0]}
                                   : {{16{shifted[15]}}, shifted[15:0]};
            default:
                return raw;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    // byte address on the data bus
    typedef logic [31:0] addr_t;

    // one write enable per byte lane
    typedef logic [3:0] strobe_t;

    // even words live in bank 0, odd words in bank 1
    typedef logic bank_t;

    localparam int BANK_BIT = 2;

    function automatic bank_t bank_of(input addr_t addr);
        return addr[BANK_BIT];
    endfunction

endpackage

`default_nettype wire

//--- source/dbus_if.sv
`default_nettype none

interface dbus_if;
    import mem_pipe_pkg::*;
    import dbus_pkg::*;

    // request side
    logic    req_valid;
    addr_t   req_addr;
    logic    req_write;
    strobe_t req_strobe;
    word_t   req_wdata;

    // response side
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;

    modport master (
        output req_valid, req_addr, req_write, req_strobe, req_wdata,
        input  addr_ok
    );

    modport slave (
        input  req_valid, req_addr, req_write, req_strobe, req_wdata,
        output addr_ok, data_ok, rdata
    );

    // observes responses only, drives nothing
    modport monitor (
        input data_ok, rdata
    );

endinterface

`default_nettype wire

//--- source/mem_req_issue.sv
`default_nettype none

module mem_req_issue (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    input  logic [1:0]           in_lane_valid,
    input  logic [1:0]           in_write,
    input  mem_pipe_pkg::msize_t in_size [2],
    input  logic [1:0]           in_unsigned,
    input  dbus_pkg::addr_t      in_addr [2],
    input  mem_pipe_pkg::word_t  in_wdata [2],
    output logic                 stall,
    output mem_pipe_pkg::msize_t pair_size [2],
    output logic [1:0]           pair_unsigned,
    output logic [1:0]           pair_offset [2],
    output logic [1:0]           pair_lane_valid,
    input  logic                 pair_done,
    dbus_if.master               bus0,
    dbus_if.master               bus1
);
    import mem_pipe_pkg::*;
    import dbus_pkg::*;

    logic       take;
    logic       busy;
    logic [1:0] req_valid;
    logic [1:0] req_write;
    logic [1:0] addr_ok;
    addr_t      req_addr [2];
    strobe_t    req_strobe [2];
    word_t      req_wdata [2];
    strobe_t    lane_strobe [2];
    word_t      lane_wdata [2];

    // a new pair may enter in the same cycle the old one completes
    assign stall = busy && !pair_done;
    assign take  = in_valid && !stall;

    assign addr_ok = {bus1.addr_ok, bus0.addr_ok};

    for (genvar i = 0; i < 2; i++) begin : g_lane
        // strobes and store data placed on the addressed byte lanes
        always_comb begin
            case (in_size[i])
                MSIZE_BYTE: begin
                    lane_strobe[i] = strobe_t'(4'b0001 << in_addr[i][1:0]);
                    lane_wdata[i]  = {4{in_wdata[i][7:0]}};
                end
                MSIZE_HALF: begin
                    lane_strobe[i] = strobe_t'(4'b0011 << in_addr[i][1:0]);
                    lane_wdata[i]  = {2{in_wdata[i][15:0]}};
                end
                default: begin
                    lane_strobe[i] = 4'b1111;
                    lane_wdata[i]  = in_wdata[i];
                end
            endcase
        end

        always_ff @(posedge clk) begin
            if (take) begin
                req_addr[i]    <= in_addr[i];
                req_strobe[i]  <= lane_strobe[i];
                req_wdata[i]   <= lane_wdata[i];
                pair_size[i]   <= in_size[i];
                pair_offset[i] <= in_addr[i][1:0];
            end
        end

        // misaligned accesses are not handled by this stage
        a_aligned: assert property (@(posedge clk) disable iff (resetn)
            (take && in_lane_valid[i]) |->
                !((in_size[i] == MSIZE_HALF && in_addr[i][0]) ||
                  (in_size[i] == MSIZE_WORD && in_addr[i][1:0] != 2'b00)));
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_write     <= in_write;
            pair_unsigned <= in_unsigned;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy            <= 1'b0;
            req_valid       <= 2'b00;
            pair_lane_valid <= 2'b00;
        end else if (take) begin
            busy            <= 1'b1;
            req_valid       <= in_lane_valid;
            pair_lane_valid <= in_lane_valid;
        end else begin
            if (pair_done)
                busy <= 1'b0;
            // drop each request once its address is taken
            req_valid <= req_valid & ~addr_ok;
        end
    end

    assign bus0.req_valid  = req_valid[0];
    assign bus0.req_addr   = req_addr[0];
    assign bus0.req_write  = req_write[0];
    assign bus0.req_strobe = req_strobe[0];
    assign bus0.req_wdata  = req_wdata[0];

    assign bus1.req_valid  = req_valid[1];
    assign bus1.req_addr   = req_addr[1];
    assign bus1.req_write  = req_write[1];
    assign bus1.req_strobe = req_strobe[1];
    assign bus1.req_wdata  = req_wdata[1];

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS   = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic  clk,
    input  logic  resetn,
    dbus_if.slave bus0,
    dbus_if.slave bus1
);
    import mem_pipe_pkg::*;
    import dbus_pkg::*;

    // word index inside one bank sits just above the bank bit
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [1:0]       req_valid;
    logic [1:0]       req_write;
    logic [1:0]       grant;
    logic             conflict;
    addr_t            req_addr [2];
    strobe_t          req_strobe [2];
    word_t            req_wdata [2];
    bank_t            bank [2];
    logic [IDX_W-1:0] widx [2];

    word_t mem_bank [2][RAM_WORDS];

    // response pipeline whose last stage drives the bus
    logic  ok_pipe [2][RAM_LATENCY];
    word_t data_pipe [2][RAM_LATENCY];

    assign req_valid     = {bus1.req_valid, bus0.req_valid};
    assign req_write     = {bus1.req_write, bus0.req_write};
    assign req_addr[0]   = bus0.req_addr;
    assign req_addr[1]   = bus1.req_addr;
    assign req_strobe[0] = bus0.req_strobe;
    assign req_strobe[1] = bus1.req_strobe;
    assign req_wdata[0]  = bus0.req_wdata;
    assign req_wdata[1]  = bus1.req_wdata;

    for (genvar i = 0; i < 2; i++) begin : g_addr
        assign bank[i] = bank_of(req_addr[i]);
        assign widx[i] = req_addr[i][IDX_W+2:3];
    end

    // one access per bank per cycle and the older lane wins
    assign conflict = req_valid[0] && req_valid[1] && (bank[0] == bank[1]);
    assign grant[0] = req_valid[0];
    assign grant[1] = req_valid[1] && !conflict;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (grant[i]) begin
                if (req_write[i]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_strobe[i][b])
                            mem_bank[bank[i]][widx[i]][8*b +: 8] <= req_wdata[i][8*b +: 8];
                    end
                    // stores answer with zero data
                    data_pipe[i][0] <= '0;
                end else begin
                    data_pipe[i][0] <= mem_bank[bank[i]][widx[i]];
                end
            end
            for (int s = 1; s < RAM_LATENCY; s++)
                data_pipe[i][s] <= data_pipe[i][s-1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (resetn) begin
                for (int s = 0; s < RAM_LATENCY; s++)
                    ok_pipe[i][s] <= 1'b0;
            end else begin
                ok_pipe[i][0] <= grant[i];
                for (int s = 1; s < RAM_LATENCY; s++)
                    ok_pipe[i][s] <= ok_pipe[i][s-1];
            end
        end
    end

    assign bus0.addr_ok = grant[0];
    assign bus1.addr_ok = grant[1];
    assign bus0.data_ok = ok_pipe[0][RAM_LATENCY-1];
    assign bus1.data_ok = ok_pipe[1][RAM_LATENCY-1];
    assign bus0.rdata   = data_pipe[0][RAM_LATENCY-1];
    assign bus1.rdata   = data_pipe[1][RAM_LATENCY-1];

    // a lane 1 request held back by a conflict must stay put
    a_hold1: assert property (@(posedge clk) disable iff (resetn)
        (req_valid[1] && !grant[1]) |=>
            (req_valid[1] && $stable(req_addr[1]) && $stable(req_write[1])
             && $stable(req_strobe[1]) && $stable(req_wdata[1])));

endmodule

`default_nettype wire

//--- source/load_capture.sv
`default_nettype none

module load_capture (
    input  logic                 clk,
    input  logic                 resetn,
    dbus_if.monitor              bus0,
    dbus_if.monitor              bus1,
    input  mem_pipe_pkg::msize_t pair_size [2],
    input  logic [1:0]           pair_unsigned,
    input  logic [1:0]           pair_offset [2],
    input  logic [1:0]           pair_lane_valid,
    output logic                 pair_done,
    output logic                 out_valid,
    output logic [1:0]           out_lane_valid,
    output mem_pipe_pkg::word_t  out_rdata [2]
);
    import mem_pipe_pkg::*;

    logic [1:0] data_ok;
    logic [1:0] saved;
    logic [1:0] lane_done;
    logic [1:0] other_pending;
    logic       finish;
    word_t      rdata [2];
    word_t      save_data [2];
    word_t      raw [2];

    assign data_ok  = {bus1.data_ok, bus0.data_ok};
    assign rdata[0] = bus0.rdata;
    assign rdata[1] = bus1.rdata;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        localparam lane_idx_t OTHER = lane_idx_t'(1 - i);

        // partner lane still has no response
        assign other_pending[i] = pair_lane_valid[OTHER] && !saved[OTHER]
                                  && !data_ok[OTHER];

        // idle lanes count as done
        assign lane_done[i] = !pair_lane_valid[i] || saved[i] || data_ok[i];

        // early data comes from the save register and late data straight from the bus
        assign raw[i] = saved[i] ? save_data[i] : rdata[i];

        always_ff @(posedge clk) begin
            if (resetn)
                saved[i] <= 1'b0;
            else if (finish)
                saved[i] <= 1'b0;
            else if (data_ok[i] && other_pending[i])
                saved[i] <= 1'b1;
        end

        always_ff @(posedge clk) begin
            if (data_ok[i] && other_pending[i])
                save_data[i] <= rdata[i];
        end

        always_ff @(posedge clk) begin
            if (finish)
                out_rdata[i] <= pair_lane_valid[i]
                    ? extract_load(raw[i], pair_offset[i], pair_size[i], pair_unsigned[i])
                    : '0;
        end

        // one response per lane per pair, and only on lanes in use
        a_single_ok: assert property (@(posedge clk) disable iff (resetn)
            data_ok[i] |-> (pair_lane_valid[i] && !saved[i]));
    end

    assign finish = (|pair_lane_valid) && (&lane_done);

    always_ff @(posedge clk) begin
        if (resetn) begin
            out_valid      <= 1'b0;
            out_lane_valid <= 2'b00;
        end else begin
            out_valid <= finish;
            if (finish)
                out_lane_valid <= pair_lane_valid;
        end
    end

    // the issue side frees the pair on the result pulse
    assign pair_done = out_valid;

endmodule

`default_nettype wire

//--- source/mem_stage_top.sv
`default_nettype none

module mem_stage_top #(
    parameter int RAM_WORDS   = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    input  logic [1:0]           in_lane_valid,
    input  logic [1:0]           in_write,
    input  mem_pipe_pkg::msize_t in_size [2],
    input  logic [1:0]           in_unsigned,
    input  dbus_pkg::addr_t      in_addr [2],
    input  mem_pipe_pkg::word_t  in_wdata [2],
    output logic                 stall,
    output logic                 out_valid,
    output logic [1:0]           out_lane_valid,
    output mem_pipe_pkg::word_t  out_rdata [2]
);
    import mem_pipe_pkg::*;

    // per-pair info handed from issue to capture
    msize_t     pair_size [2];
    logic [1:0] pair_unsigned;
    logic [1:0] pair_offset [2];
    logic [1:0] pair_lane_valid;
    logic       pair_done;

    dbus_if bus0 ();
    dbus_if bus1 ();

    mem_req_issue u_issue (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_lane_valid   (in_lane_valid),
        .in_write        (in_write),
        .in_size         (in_size),
        .in_unsigned     (in_unsigned),
        .in_addr         (in_addr),
        .in_wdata        (in_wdata),
        .stall           (stall),
        .pair_size       (pair_size),
        .pair_unsigned   (pair_unsigned),
        .pair_offset     (pair_offset),
        .pair_lane_valid (pair_lane_valid),
        .pair_done       (pair_done),
        .bus0            (bus0),
        .bus1            (bus1)
    );

    data_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_ram (
        .clk    (clk),
        .resetn (resetn),
        .bus0   (bus0),
        .bus1   (bus1)
    );

    load_capture u_capture (
        .clk             (clk),
        .resetn          (resetn),
        .bus0            (bus0),
        .bus1            (bus1),
        .pair_size       (pair_size),
        .pair_unsigned   (pair_unsigned),
        .pair_offset     (pair_offset),
        .pair_lane_valid (pair_lane_valid),
        .pair_done       (pair_done),
        .out_valid       (out_valid),
        .out_lane_valid  (out_lane_valid),
        .out_rdata       (out_rdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pipe_pkg::*;
    import dbus_pkg::*;

    localparam int RAM_WORDS      = 256;
    localparam int RAM_LATENCY    = 2;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_PAIRS   = 200;
    // eight words with four per bank so conflicts and hazards are common
    localparam int TEST_WORDS     = 8;

    logic       clk;
    logic       resetn;
    logic       in_valid;
    logic [1:0] in_lane_valid;
    logic [1:0] in_write;
    msize_t     in_size [2];
    logic [1:0] in_unsigned;
    addr_t      in_addr [2];
    word_t      in_wdata [2];
    logic       stall;
    logic       out_valid;
    logic [1:0] out_lane_valid;
    word_t      out_rdata [2];

    // next pair is filled lane by lane before it is sent
    logic [1:0] st_valid;
    logic [1:0] st_write;
    logic [1:0] st_uns;
    msize_t     st_size [2];
    addr_t      st_addr [2];
    word_t      st_wdata [2];

    word_t  model_mem [TEST_WORDS];
    integer seed = 32'hb03f9508;
    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     pair_count = 0;
    logic   timed_out = 1'b0;

    mem_stage_top #(
        .RAM_WORDS   (RAM_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) dut0 (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_lane_valid  (in_lane_valid),
        .in_write       (in_write),
        .in_size        (in_size),
        .in_unsigned    (in_unsigned),
        .in_addr        (in_addr),
        .in_wdata       (in_wdata),
        .stall          (stall),
        .out_valid      (out_valid),
        .out_lane_valid (out_lane_valid),
        .out_rdata      (out_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // field of a word as a load of this size and offset must see it
    function automatic word_t expect_load(input word_t w, input logic [1:0] off,
                                          input msize_t sz, input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       result;
        case (off)
            2'd0:    b = w[7:0];
            2'd1:    b = w[15:8];
            2'd2:    b = w[23:16];
            default: b = w[31:24];
        endcase
        h = off[1] ? w[31:16] : w[15:0];
        case (sz)
            MSIZE_BYTE: result = uns ? {24'h0, b} : {{24{b[7]}}, b};
            MSIZE_HALF: result = uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:    result = w;
        endcase
        return result;
    endfunction

    task automatic apply_store(input logic [2:0] widx, input logic [1:0] off,
                               input msize_t sz, input word_t data);
        int pos;
        pos = 8 * int'(off);
        case (sz)
            MSIZE_BYTE: model_mem[widx][pos +: 8] = data[7:0];
            MSIZE_HALF: model_mem[widx][pos +: 16] = data[15:0];
            default:    model_mem[widx] = data;
        endcase
    endtask

    task automatic set_lane(input int lane, input logic valid, input logic write,
                            input msize_t sz, input logic uns, input int widx,
                            input int off, input word_t data);
        st_valid[lane] = valid;
        st_write[lane] = write;
        st_uns[lane]   = uns;
        st_size[lane]  = sz;
        st_addr[lane]  = addr_t'(widx * 4 + off);
        st_wdata[lane] = data;
    endtask

    task automatic random_lane(input int lane, input logic valid);
        word_t  rnd;
        word_t  data;
        msize_t sz;
        int     off;
        rnd  = $random(seed);
        data = $random(seed);
        case (rnd[1:0])
            2'd0: begin
                sz  = MSIZE_BYTE;
                off = int'(rnd[3:2]);
            end
            2'd1: begin
                sz  = MSIZE_HALF;
                off = int'({rnd[3], 1'b0});
            end
            default: begin
                sz  = MSIZE_WORD;
                off = 0;
            end
        endcase
        set_lane(lane, valid, rnd[7], sz, rnd[8], int'(rnd[6:4]), off, data);
    endtask

    task automatic wait_idle(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = !stall;
            n++;
        end
    endtask

    // stall must hold high for the whole wait
    task automatic wait_result(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = out_valid;
            if (!ok)
                check_flag("stall", stall, 1'b1);
            n++;
        end
    endtask

    task automatic run_pair();
        word_t      exp_data [2];
        logic [2:0] widx;
        logic       ok;
        if (timed_out)
            return;
        // model goes lane 0 first, so lane 1 sees its store
        for (int i = 0; i < 2; i++) begin
            exp_data[i] = 32'h0;
            if (st_valid[i]) begin
                widx = st_addr[i][4:2];
                if (st_write[i])
                    apply_store(widx, st_addr[i][1:0], st_size[i], st_wdata[i]);
                else
                    exp_data[i] = expect_load(model_mem[widx], st_addr[i][1:0],
                                              st_size[i], st_uns[i]);
            end
        end
        wait_idle(ok);
        if (!ok) begin
            $display("Timeout: stall stayed high before pair %0d", pair_count);
            timeout_count++;
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        in_valid      <= 1'b1;
        in_lane_valid <= st_valid;
        in_write      <= st_write;
        in_unsigned   <= st_uns;
        for (int i = 0; i < 2; i++) begin
            in_size[i]  <= st_size[i];
            in_addr[i]  <= st_addr[i];
            in_wdata[i] <= st_wdata[i];
        end
        @(posedge clk);
        in_valid      <= 1'b0;
        in_lane_valid <= 2'b00;
        wait_result(ok);
        if (!ok) begin
            $display("Timeout: no out_valid for pair %0d", pair_count);
            timeout_count++;
            timed_out = 1'b1;
            return;
        end
        check_flag("stall", stall, 1'b0);
        for (int i = 0; i < 2; i++) begin
            check_flag($sformatf("out_lane_valid[%0d]", i), out_lane_valid[i], st_valid[i]);
            check_word($sformatf("out_rdata[%0d]", i), out_rdata[i], exp_data[i]);
        end
        pair_count++;
    endtask

    initial begin
        word_t rnd;
        resetn        = 1'b1;
        in_valid      = 1'b0;
        in_lane_valid = 2'b00;
        in_write      = 2'b00;
        in_unsigned   = 2'b00;
        for (int i = 0; i < 2; i++) begin
            in_size[i]  = MSIZE_WORD;
            in_addr[i]  = 32'h0;
            in_wdata[i] = 32'h0;
        end
        repeat (3) @(posedge clk);
        resetn <= 1'b0;

        // quiet outputs until the first pair
        repeat (5) begin
            @(negedge clk);
            check_flag("stall", stall, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
        end

        // fill every test word with the lanes in different banks
        for (int k = 0; k < TEST_WORDS / 2; k++) begin
            rnd = $random(seed);
            set_lane(0, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 2 * k, 0, (k == 0) ? 32'h80ff7f01 : rnd);
            rnd = $random(seed);
            set_lane(1, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 2 * k + 1, 0,
                     (k == 1) ? 32'h7abc8123 : rnd);
            run_pair();
        end

        // word loads in the same bank and then in different banks
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 0, 0, 32'h0);
        set_lane(1, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 2, 0, 32'h0);
        run_pair();
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 3, 0, 32'h0);
        set_lane(1, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 0, 0, 32'h0);
        run_pair();
        set_lane(0, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 4, 0, 32'hdeadbeef);
        set_lane(1, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 6, 0, 32'h13579bdf);
        run_pair();
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 6, 0, 32'h0);
        set_lane(1, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 4, 0, 32'h0);
        run_pair();

        // byte and halfword loads at every offset with both extensions
        for (int off = 0; off < 4; off++) begin
            for (int u = 0; u < 2; u++) begin
                set_lane(0, 1'b1, 1'b0, MSIZE_BYTE, u[0], 0, off, 32'h0);
                set_lane(1, 1'b1, 1'b0, MSIZE_HALF, u[0], 3, off & 2, 32'h0);
                run_pair();
            end
        end

        // partial stores then word loads over the same words
        set_lane(0, 1'b1, 1'b1, MSIZE_BYTE, 1'b0, 5, 1, 32'h000000a5);
        set_lane(1, 1'b1, 1'b1, MSIZE_HALF, 1'b0, 7, 2, 32'h0000c3d2);
        run_pair();
        set_lane(0, 1'b1, 1'b1, MSIZE_BYTE, 1'b0, 2, 3, 32'h0000005a);
        set_lane(1, 1'b1, 1'b1, MSIZE_HALF, 1'b0, 2, 0, 32'h00006e7f);
        run_pair();
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 5, 0, 32'h0);
        set_lane(1, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 7, 0, 32'h0);
        run_pair();
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 2, 0, 32'h0);
        set_lane(1, 1'b0, 1'b0, MSIZE_WORD, 1'b0, 0, 0, 32'h0);
        run_pair();

        // store then load of one word inside a pair in both orders
        set_lane(0, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 1, 0, 32'h5af0c381);
        set_lane(1, 1'b1, 1'b0, MSIZE_BYTE, 1'b0, 1, 2, 32'h0);
        run_pair();
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 6, 0, 32'h0);
        set_lane(1, 1'b1, 1'b1, MSIZE_WORD, 1'b0, 6, 0, 32'h2468ace0);
        run_pair();

        // one lane only
        set_lane(0, 1'b1, 1'b0, MSIZE_WORD, 1'b0, 6, 0, 32'h0);
        set_lane(1, 1'b0, 1'b0, MSIZE_WORD, 1'b0, 0, 0, 32'h0);
        run_pair();
        set_lane(0, 1'b0, 1'b0, MSIZE_WORD, 1'b0, 0, 0, 32'h0);
        set_lane(1, 1'b1, 1'b0, MSIZE_HALF, 1'b1, 1, 2, 32'h0);
        run_pair();

        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            rnd = $random(seed);
            random_lane(0, rnd[1:0] != 2'd1);
            random_lane(1, rnd[1:0] != 2'd0);
            run_pair();
        end

        $display("run complete: %0d pairs, %0d mismatches, %0d timeouts",
                 pair_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
source/mem_pipe_pkg.sv
source/dbus_pkg.sv
source/dbus_if.sv
source/mem_req_issue.sv
source/data_ram.sv
source/load_capture.sv
source/mem_stage_top.sv
sim/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_stage \
    -f verilog.f -o tb_mem_stage

if ! ./obj_dir/tb_mem_stage > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
